// ==== include/mpWrite_defs.svh ====
// Write-request port widths
// Sizes of the line address, fill data, beat number and client number shared
// by the sequencers, the arbiter, the tracker and the checker

`ifndef MPWRITE_DEFS_SVH
`define MPWRITE_DEFS_SVH

// Line address width, counted in cache lines
`define MP_ADDR_W 16

// Fill word and beat data width
`define MP_DATA_W 32

// Beat number within a packet, wide enough for four lines
`define MP_CLNUM_W 2

// Number of write clients merged onto the output channel
`define MP_NUM_CLIENTS 2

// Client number carried with each output beat
`define MP_CLIENT_W ($clog2(`MP_NUM_CLIENTS))

// Width of the completed-packet counter
`define MP_PKTCNT_W 16

`endif

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the write-request testbench with Verilator, runs it and
# decides the result from the simulation log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=multiWriteSim

verilator --binary --timing -Wno-fatal -f tb.f --top-module multiWriteTb \
    -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "TEST PASS" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// ==== sim/multiWriteTb.sv ====
// Write-request subsystem testbench
// Issues a table of write commands on both clients under random
// back-pressure and checks every output beat against per-client queues
// built from the line-fill rules, plus packet locking and checker outputs

`timescale 1ns/1ps
`default_nettype none

`include "mpWrite_defs.svh"

module multiWriteTb;

    localparam int NUM_ENTRIES     = 14;
    localparam int RESET_CYCLES    = 3;
    localparam int CYCLES_PER_BEAT = 20;

    // One table row: the command and whether its start is misaligned
    typedef struct packed {
        logic                  client;
        logic [`MP_ADDR_W-1:0] addr;
        mpWritePkg::tClLen     len;
        logic [`MP_DATA_W-1:0] fill;
        logic                  misaligned;
    } tCmdEntry;

    // One expected beat on the output channel
    typedef struct packed {
        logic [`MP_ADDR_W-1:0] addr;
        mpWritePkg::tClLen     len;
        logic                  sop;
        logic [`MP_DATA_W-1:0] data;
        logic                  misaligned;
    } tExpBeat;

    logic                    clk;
    logic                    reset;
    logic                    cmdValid0;
    logic [`MP_ADDR_W-1:0]   cmdAddr0;
    mpWritePkg::tClLen       cmdLen0;
    logic [`MP_DATA_W-1:0]   cmdData0;
    logic                    cmdReady0;
    logic                    cmdValid1;
    logic [`MP_ADDR_W-1:0]   cmdAddr1;
    mpWritePkg::tClLen       cmdLen1;
    logic [`MP_DATA_W-1:0]   cmdData1;
    logic                    cmdReady1;
    logic                    almostFull;
    logic                    txValid;
    logic [`MP_ADDR_W-1:0]   txAddr;
    mpWritePkg::tClLen       txLen;
    logic                    txSop;
    logic [`MP_DATA_W-1:0]   txData;
    logic [`MP_CLIENT_W-1:0] txClient;
    logic                    alignError;
    logic [`MP_PKTCNT_W-1:0] packetCount;

    tCmdEntry                cmdTable [NUM_ENTRIES];
    tExpBeat                 expQ0 [$];
    tExpBeat                 expQ1 [$];

    logic [15:0]             lfsrState;
    int                      cycleCount;
    int                      cycleLimit;
    int                      pktExpected;
    logic                    errExpected;
    logic                    inPacket;
    logic [`MP_CLIENT_W-1:0] lockClient;
    int                      beatsLeft;

    multiWriteTop u_dut
    (
        .clk         (clk),
        .reset       (reset),
        .cmdValid0   (cmdValid0),
        .cmdAddr0    (cmdAddr0),
        .cmdLen0     (cmdLen0),
        .cmdData0    (cmdData0),
        .cmdReady0   (cmdReady0),
        .cmdValid1   (cmdValid1),
        .cmdAddr1    (cmdAddr1),
        .cmdLen1     (cmdLen1),
        .cmdData1    (cmdData1),
        .cmdReady1   (cmdReady1),
        .almostFull  (almostFull),
        .txValid     (txValid),
        .txAddr      (txAddr),
        .txLen       (txLen),
        .txSop       (txSop),
        .txData      (txData),
        .txClient    (txClient),
        .alignError  (alignError),
        .packetCount (packetCount)
    );

    // 20 ns clock
    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Compares one value and stops the run on a mismatch
    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    // Stops the run on a failure that is not a value mismatch
    task automatic reportFailure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        $display("TEST FAIL");
        $fatal(1, "%s", what);
    endtask

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // One step per random bit taken
    task automatic takeBit(output logic value);
        lfsrState = lfsrStep(lfsrState);
        value     = lfsrState[0];
    endtask

    task automatic setEntry(input int idx, input logic client,
                            input logic [`MP_ADDR_W-1:0] addr,
                            input mpWritePkg::tClLen len,
                            input logic [`MP_DATA_W-1:0] fill,
                            input logic misaligned);
        cmdTable[idx].client     = client;
        cmdTable[idx].addr       = addr;
        cmdTable[idx].len        = len;
        cmdTable[idx].fill       = fill;
        cmdTable[idx].misaligned = misaligned;
    endtask

    // Clients alternate so that packets compete for the channel
    // The last two rows start off their length boundary
    task automatic loadTable();
        setEntry(0,  1'b0, 16'h0010, mpWritePkg::eClLen4, 32'h1000_0000, 1'b0);
        setEntry(1,  1'b1, 16'h0200, mpWritePkg::eClLen4, 32'h2000_0000, 1'b0);
        setEntry(2,  1'b0, 16'h0022, mpWritePkg::eClLen2, 32'h1100_0010, 1'b0);
        setEntry(3,  1'b1, 16'h0301, mpWritePkg::eClLen1, 32'h2100_0020, 1'b0);
        setEntry(4,  1'b0, 16'h0044, mpWritePkg::eClLen4, 32'h12AB_CDEF, 1'b0);
        setEntry(5,  1'b1, 16'h0406, mpWritePkg::eClLen2, 32'h2234_5678, 1'b0);
        setEntry(6,  1'b1, 16'h0408, mpWritePkg::eClLen4, 32'h2300_FFFE, 1'b0);
        setEntry(7,  1'b0, 16'h0055, mpWritePkg::eClLen1, 32'h13FF_FFFF, 1'b0);
        // Fill word wraps past the top of the data range
        setEntry(8,  1'b0, 16'h0058, mpWritePkg::eClLen2, 32'hFFFF_FFFF, 1'b0);
        setEntry(9,  1'b1, 16'h04FC, mpWritePkg::eClLen4, 32'h2400_0000, 1'b0);
        setEntry(10, 1'b0, 16'hFFFC, mpWritePkg::eClLen4, 32'h1500_0000, 1'b0);
        setEntry(11, 1'b1, 16'h0500, mpWritePkg::eClLen2, 32'h2500_0000, 1'b0);
        setEntry(12, 1'b0, 16'h0102, mpWritePkg::eClLen4, 32'h1600_0000, 1'b1);
        setEntry(13, 1'b1, 16'h0511, mpWritePkg::eClLen2, 32'h2600_0000, 1'b1);
    endtask

    // Checks one output beat and the packet lock, then updates the model
    task automatic checkBeat();
        tExpBeat exp;
        // A continuation beat must come from the client that opened the packet
        if (!txSop)
        begin
            if (!inPacket)
                reportFailure("continuation beat seen with no packet open");
            checkValue("txClient", 64'(txClient), 64'(lockClient));
        end
        else if (inPacket)
        begin
            reportFailure("new packet started before the open packet ended");
        end

        if (txClient == '0)
        begin
            if (expQ0.size() == 0)
                reportFailure("beat from client 0 with no command outstanding");
            else
                exp = expQ0.pop_front();
        end
        else
        begin
            if (expQ1.size() == 0)
                reportFailure("beat from client 1 with no command outstanding");
            else
                exp = expQ1.pop_front();
        end

        checkValue("txAddr", 64'(txAddr), 64'(exp.addr));
        checkValue("txLen", 64'(txLen), 64'(exp.len));
        checkValue("txSop", 64'(txSop), 64'(exp.sop));
        checkValue("txData", 64'(txData), 64'(exp.data));

        if (txSop)
        begin
            lockClient = txClient;
            beatsLeft  = int'(exp.len);
            // Sticky error is due on the edge after the first bad beat
            if (exp.misaligned)
                errExpected = 1'b1;
        end
        else
        begin
            beatsLeft = beatsLeft - 1;
        end
        inPacket = (beatsLeft != 0);
        if (beatsLeft == 0)
            pktExpected = pktExpected + 1;
    endtask

    // Samples the outputs at the falling edge, where they are stable
    task automatic checkOutputs();
        // almostFull still holds the level seen by the last rising edge
        if (almostFull)
            checkValue("txValid", 64'(txValid), 64'(0));
        checkValue("alignError", 64'(alignError), 64'(errExpected));
        checkValue("packetCount", 64'(packetCount), 64'(pktExpected));
        if (txValid)
            checkBeat();
    endtask

    // Advances to the next falling edge, checks, then drives new inputs
    task automatic stepCycle();
        logic afBit;
        @(negedge clk);
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit)
        begin
            $display("Timeout: run went past %0d cycles without finishing",
                     cycleLimit);
            $display("TEST FAIL");
            $fatal(1, "Cycle limit reached");
        end
        checkOutputs();
        // Command strobes last one cycle
        cmdValid0 = 1'b0;
        cmdValid1 = 1'b0;
        takeBit(afBit);
        almostFull = afBit;
    endtask

    function automatic logic clientReady(input logic client);
        return client ? cmdReady1 : cmdReady0;
    endfunction

    // Drives one table row and queues its expected beats
    task automatic issueCommand(input int idx);
        tCmdEntry ent;
        tExpBeat  beat;
        int       lastNum;
        ent     = cmdTable[idx];
        lastNum = int'(ent.len);
        for (int b = 0; b <= lastNum; b++)
        begin
            beat.addr       = ent.addr + `MP_ADDR_W'(b);
            beat.len        = ent.len;
            beat.sop        = (b == 0);
            beat.data       = ent.fill + `MP_DATA_W'(b);
            beat.misaligned = ent.misaligned;
            if (ent.client)
                expQ1.push_back(beat);
            else
                expQ0.push_back(beat);
        end

        if (ent.client)
        begin
            cmdValid1 = 1'b1;
            cmdAddr1  = ent.addr;
            cmdLen1   = ent.len;
            cmdData1  = ent.fill;
        end
        else
        begin
            cmdValid0 = 1'b1;
            cmdAddr0  = ent.addr;
            cmdLen0   = ent.len;
            cmdData0  = ent.fill;
        end
    endtask

    initial
    begin
        logic delayBit;
        int   totalBeats;

        reset       = 1'b1;
        cmdValid0   = 1'b0;
        cmdAddr0    = '0;
        cmdLen0     = mpWritePkg::eClLen1;
        cmdData0    = '0;
        cmdValid1   = 1'b0;
        cmdAddr1    = '0;
        cmdLen1     = mpWritePkg::eClLen1;
        cmdData1    = '0;
        almostFull  = 1'b0;
        lfsrState   = 16'd46699;
        cycleCount  = 0;
        pktExpected = 0;
        errExpected = 1'b0;
        inPacket    = 1'b0;
        lockClient  = '0;
        beatsLeft   = 0;

        loadTable();
        totalBeats = 0;
        for (int i = 0; i < NUM_ENTRIES; i++)
            totalBeats = totalBeats + int'(cmdTable[i].len) + 1;
        cycleLimit = CYCLES_PER_BEAT * totalBeats + RESET_CYCLES;

        // Reset spans three rising edges and is released on a falling edge
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Idle state straight after reset
        checkValue("txValid", 64'(txValid), 64'(0));
        checkValue("alignError", 64'(alignError), 64'(0));
        checkValue("packetCount", 64'(packetCount), 64'(0));
        checkValue("cmdReady0", 64'(cmdReady0), 64'(1));
        checkValue("cmdReady1", 64'(cmdReady1), 64'(1));

        for (int i = 0; i < NUM_ENTRIES; i++)
        begin
            takeBit(delayBit);
            if (delayBit)
                stepCycle();
            while (!clientReady(cmdTable[i].client))
                stepCycle();
            issueCommand(i);
            stepCycle();
        end

        // Drain every outstanding beat, then let the counters settle
        while ((expQ0.size() != 0) || (expQ1.size() != 0))
            stepCycle();
        repeat (2) stepCycle();

        checkValue("packetCount", 64'(packetCount), 64'(NUM_ENTRIES));
        checkValue("alignError", 64'(alignError), 64'(1));
        checkValue("cmdReady0", 64'(cmdReady0), 64'(1));
        checkValue("cmdReady1", 64'(cmdReady1), 64'(1));
        if (inPacket)
        begin
            reportFailure("a packet was still open after all beats drained");
        end
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== source/lineFillSequencer.sv ====
// Line-fill sequencer
// Expands one write command (start line, length code, fill word) into a
// packet of one beat per cache line. Beat zero carries the start-of-packet
// flag and each beat carries the fill word plus its beat number

`timescale 1ns/1ps
`default_nettype none

`include "mpWrite_defs.svh"

module lineFillSequencer
(
    input  logic                    clk,
    input  logic                    reset,

    // Command port, cmdValid is a one-cycle strobe taken while cmdReady is high
    input  logic                    cmdValid,
    input  logic [`MP_ADDR_W-1:0]   cmdAddr,
    input  mpWritePkg::tClLen       cmdLen,
    input  logic [`MP_DATA_W-1:0]   cmdData,
    output logic                    cmdReady,

    // Beat offered to the arbiter, held until beatTake
    output logic                    beatValid,
    output logic [`MP_ADDR_W-1:0]   beatAddr,
    output mpWritePkg::tClLen       beatLen,
    output logic                    beatSop,
    output logic [`MP_DATA_W-1:0]   beatData,
    input  logic                    beatTake
);

    mpWritePkg::tSeqState           seqState;
    mpWritePkg::tClNum              beatNum;

    // Latched command
    logic [`MP_ADDR_W-1:0]          addrReg;
    mpWritePkg::tClLen              lenReg;
    logic [`MP_DATA_W-1:0]          dataReg;

    logic                           lastBeat;

    // The beat counter reaches the length code on the final beat
    assign lastBeat = (beatNum == mpWritePkg::tClNum'(lenReg));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            seqState <= mpWritePkg::eSeqIdle;
            beatNum  <= '0;
        end
        else
        begin
            case (seqState)
                mpWritePkg::eSeqIdle:
                begin
                    if (cmdValid)
                    begin
                        seqState <= mpWritePkg::eSeqSend;
                        beatNum  <= '0;
                    end
                end

                mpWritePkg::eSeqSend:
                begin
                    // Advance only when the arbiter has taken the current beat
                    if (beatTake)
                    begin
                        if (lastBeat)
                        begin
                            seqState <= mpWritePkg::eSeqIdle;
                            beatNum  <= '0;
                        end
                        else
                        begin
                            beatNum <= beatNum + mpWritePkg::tClNum'(1);
                        end
                    end
                end

                default:
                begin
                    seqState <= mpWritePkg::eSeqIdle;
                end
            endcase
        end
    end

    // Command payload is captured on acceptance and held for the whole packet
    always_ff @(posedge clk)
    begin
        if ((seqState == mpWritePkg::eSeqIdle) && cmdValid)
        begin
            addrReg <= cmdAddr;
            lenReg  <= cmdLen;
            dataReg <= cmdData;
        end
    end

    assign cmdReady  = (seqState == mpWritePkg::eSeqIdle);
    assign beatValid = (seqState == mpWritePkg::eSeqSend);

    // The start address is passed on as given, even when it is not aligned
    // to the packet length
    assign beatAddr = addrReg + `MP_ADDR_W'(beatNum);
    assign beatLen  = lenReg;
    assign beatSop  = (beatNum == '0);
    assign beatData = dataReg + `MP_DATA_W'(beatNum);

endmodule

`default_nettype wire

// ==== source/mpWritePkg.sv ====
// Write-request port types
// Line-length encoding, beat number and the state enums of the sequencer
// and arbiter FSMs

`default_nettype none

`include "mpWrite_defs.svh"

package mpWritePkg;

    // Beat number within a multi-line packet
    typedef logic [`MP_CLNUM_W-1:0] tClNum;

    // Packet length code
    // The code is the number of the last beat, so a beat counter compares
    // directly against it and the code also works as an alignment mask
    typedef enum logic [1:0]
    {
        eClLen1 = 2'd0,
        eClLen2 = 2'd1,
        eClLen4 = 2'd3
    } tClLen;

    // Line-fill sequencer FSM
    typedef enum logic
    {
        eSeqIdle,
        eSeqSend
    } tSeqState;

    // Arbiter FSM
    // In eArbLocked only the client that started the current packet is
    // served, so the beats of two packets never interleave
    typedef enum logic
    {
        eArbOpen,
        eArbLocked
    } tArbState;

endpackage

`default_nettype wire

// ==== source/multiWriteTop.sv ====
// Multi-client write-request subsystem
// Two line-fill sequencers feed a packet-locked arbiter. The merged output
// channel is followed by the beat tracker and the request checker

`timescale 1ns/1ps
`default_nettype none

`include "mpWrite_defs.svh"

module multiWriteTop
(
    input  logic                    clk,
    input  logic                    reset,

    // Client 0 command port
    input  logic                    cmdValid0,
    input  logic [`MP_ADDR_W-1:0]   cmdAddr0,
    input  mpWritePkg::tClLen       cmdLen0,
    input  logic [`MP_DATA_W-1:0]   cmdData0,
    output logic                    cmdReady0,

    // Client 1 command port
    input  logic                    cmdValid1,
    input  logic [`MP_ADDR_W-1:0]   cmdAddr1,
    input  mpWritePkg::tClLen       cmdLen1,
    input  logic [`MP_DATA_W-1:0]   cmdData1,
    output logic                    cmdReady1,

    input  logic                    almostFull,

    // Output write channel
    output logic                    txValid,
    output logic [`MP_ADDR_W-1:0]   txAddr,
    output mpWritePkg::tClLen       txLen,
    output logic                    txSop,
    output logic [`MP_DATA_W-1:0]   txData,
    output logic [`MP_CLIENT_W-1:0] txClient,

    // Checker results
    output logic                    alignError,
    output logic [`MP_PKTCNT_W-1:0] packetCount
);

    // Sequencer to arbiter beats
    logic                           beatValid0;
    logic [`MP_ADDR_W-1:0]          beatAddr0;
    mpWritePkg::tClLen              beatLen0;
    logic                           beatSop0;
    logic [`MP_DATA_W-1:0]          beatData0;
    logic                           beatTake0;

    logic                           beatValid1;
    logic [`MP_ADDR_W-1:0]          beatAddr1;
    mpWritePkg::tClLen              beatLen1;
    logic                           beatSop1;
    logic [`MP_DATA_W-1:0]          beatData1;
    logic                           beatTake1;

    // Tracker phase shared by the arbiter and the checker
    logic                           packetActive;
    mpWritePkg::tClNum              nextBeatNum;

    lineFillSequencer u_seq0
    (
        .clk       (clk),
        .reset     (reset),
        .cmdValid  (cmdValid0),
        .cmdAddr   (cmdAddr0),
        .cmdLen    (cmdLen0),
        .cmdData   (cmdData0),
        .cmdReady  (cmdReady0),
        .beatValid (beatValid0),
        .beatAddr  (beatAddr0),
        .beatLen   (beatLen0),
        .beatSop   (beatSop0),
        .beatData  (beatData0),
        .beatTake  (beatTake0)
    );

    lineFillSequencer u_seq1
    (
        .clk       (clk),
        .reset     (reset),
        .cmdValid  (cmdValid1),
        .cmdAddr   (cmdAddr1),
        .cmdLen    (cmdLen1),
        .cmdData   (cmdData1),
        .cmdReady  (cmdReady1),
        .beatValid (beatValid1),
        .beatAddr  (beatAddr1),
        .beatLen   (beatLen1),
        .beatSop   (beatSop1),
        .beatData  (beatData1),
        .beatTake  (beatTake1)
    );

    writeArbiter u_arb
    (
        .clk          (clk),
        .reset        (reset),
        .beatValid0   (beatValid0),
        .beatAddr0    (beatAddr0),
        .beatLen0     (beatLen0),
        .beatSop0     (beatSop0),
        .beatData0    (beatData0),
        .beatTake0    (beatTake0),
        .beatValid1   (beatValid1),
        .beatAddr1    (beatAddr1),
        .beatLen1     (beatLen1),
        .beatSop1     (beatSop1),
        .beatData1    (beatData1),
        .beatTake1    (beatTake1),
        .almostFull   (almostFull),
        .packetActive (packetActive),
        .txValid      (txValid),
        .txAddr       (txAddr),
        .txLen        (txLen),
        .txSop        (txSop),
        .txData       (txData),
        .txClient     (txClient)
    );

    multiWriteTracker u_track
    (
        .clk          (clk),
        .reset        (reset),
        .txValid      (txValid),
        .txSop        (txSop),
        .txLen        (txLen),
        .packetActive (packetActive),
        .nextBeatNum  (nextBeatNum)
    );

    writeRequestChecker u_check
    (
        .clk         (clk),
        .reset       (reset),
        .txValid     (txValid),
        .txAddr      (txAddr),
        .txLen       (txLen),
        .nextBeatNum (nextBeatNum),
        .alignError  (alignError),
        .packetCount (packetCount)
    );

endmodule

`default_nettype wire

// ==== source/multiWriteTracker.sv ====
// Multi-line write beat tracker
// Follows the beats on the merged write channel and reports the number of
// the next expected beat and whether a packet is in progress

`timescale 1ns/1ps
`default_nettype none

`include "mpWrite_defs.svh"

module multiWriteTracker
(
    input  logic                    clk,
    input  logic                    reset,

    // Output channel being watched
    input  logic                    txValid,
    // Start-of-packet flag of the watched beat
    input  logic                    txSop,
    input  mpWritePkg::tClLen       txLen,

    // High between the first and the last beat of a multi-line packet
    output logic                    packetActive,
    // Beat number expected on the next valid beat
    output mpWritePkg::tClNum       nextBeatNum
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            nextBeatNum  <= '0;
            packetActive <= 1'b0;
        end
        else if (txValid)
        begin
            // The length code is the number of the last beat
            if (nextBeatNum == mpWritePkg::tClNum'(txLen))
            begin
                // Last beat of the packet
                nextBeatNum  <= '0;
                packetActive <= 1'b0;
            end
            else
            begin
                nextBeatNum  <= nextBeatNum + mpWritePkg::tClNum'(1);
                packetActive <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/writeArbiter.sv ====
// Write-channel arbiter
// Merges two line-fill sequencers onto one registered output channel.
// Clients are served round-robin, and a multi-line packet holds the grant
// until the beat tracker shows that its last beat has gone out

`timescale 1ns/1ps
`default_nettype none

`include "mpWrite_defs.svh"

module writeArbiter
(
    input  logic                    clk,
    input  logic                    reset,

    // Client 0 beat
    input  logic                    beatValid0,
    input  logic [`MP_ADDR_W-1:0]   beatAddr0,
    input  mpWritePkg::tClLen       beatLen0,
    input  logic                    beatSop0,
    input  logic [`MP_DATA_W-1:0]   beatData0,
    output logic                    beatTake0,

    // Client 1 beat
    input  logic                    beatValid1,
    input  logic [`MP_ADDR_W-1:0]   beatAddr1,
    input  mpWritePkg::tClLen       beatLen1,
    input  logic                    beatSop1,
    input  logic [`MP_DATA_W-1:0]   beatData1,
    output logic                    beatTake1,

    // Back-pressure from the output side
    input  logic                    almostFull,
    // Packet phase from the beat tracker
    input  logic                    packetActive,

    // Registered output channel
    output logic                    txValid,
    output logic [`MP_ADDR_W-1:0]   txAddr,
    output mpWritePkg::tClLen       txLen,
    output logic                    txSop,
    output logic [`MP_DATA_W-1:0]   txData,
    output logic [`MP_CLIENT_W-1:0] txClient
);

    mpWritePkg::tArbState           arbState;

    // Client of the most recent grant, which is also the locked client
    logic [`MP_CLIENT_W-1:0]        lastGrant;
    logic                           activeDly;

    logic                           activeFall;
    logic                           locked;
    logic [`MP_CLIENT_W-1:0]        grant;
    logic                           grantOne;
    logic                           grantValid;
    logic                           grantSop;
    mpWritePkg::tClLen              grantLen;
    logic                           take;

    always_comb
    begin
        // The tracker drops packetActive on the edge after the last beat
        // leaves, so a falling level marks the end of the locked packet
        activeFall = activeDly && !packetActive;
        locked     = (arbState == mpWritePkg::eArbLocked) && !activeFall;

        if (locked)
        begin
            grant = lastGrant;
        end
        else if (beatValid1 && ((lastGrant == '0) || !beatValid0))
        begin
            // Client 1 wins when client 0 had the last turn or is idle
            grant = (`MP_CLIENT_W)'(1);
        end
        else
        begin
            grant = '0;
        end

        grantOne   = (grant != '0);
        grantValid = grantOne ? beatValid1 : beatValid0;
        grantSop   = grantOne ? beatSop1 : beatSop0;
        grantLen   = grantOne ? beatLen1 : beatLen0;
        take       = grantValid && !almostFull;
    end

    assign beatTake0 = take && !grantOne;
    assign beatTake1 = take && grantOne;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            arbState  <= mpWritePkg::eArbOpen;
            lastGrant <= (`MP_CLIENT_W)'(1);
            activeDly <= 1'b0;
            txValid   <= 1'b0;
        end
        else
        begin
            activeDly <= packetActive;
            txValid   <= take;

            if (take)
            begin
                lastGrant <= grant;
            end

            // A first beat of two or four lines locks onto its client
            if (take && grantSop && (grantLen != mpWritePkg::eClLen1))
            begin
                arbState <= mpWritePkg::eArbLocked;
            end
            else if (activeFall)
            begin
                arbState <= mpWritePkg::eArbOpen;
            end
        end
    end

    // Output payload follows the granted beat
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            txAddr   <= grantOne ? beatAddr1 : beatAddr0;
            txLen    <= grantLen;
            txSop    <= grantSop;
            txData   <= grantOne ? beatData1 : beatData0;
            txClient <= grant;
        end
    end

endmodule

`default_nettype wire

// ==== source/writeRequestChecker.sv ====
// Write-request checker
// Watches the output channel, flags a packet whose start line is not
// aligned to its length and counts packets whose last beat has passed

`timescale 1ns/1ps
`default_nettype none

`include "mpWrite_defs.svh"

module writeRequestChecker
(
    input  logic                    clk,
    input  logic                    reset,

    // Output channel being watched
    input  logic                    txValid,
    input  logic [`MP_ADDR_W-1:0]   txAddr,
    input  mpWritePkg::tClLen       txLen,

    // Beat phase from the tracker
    input  mpWritePkg::tClNum       nextBeatNum,

    // Sticky until reset
    output logic                    alignError,
    output logic [`MP_PKTCNT_W-1:0] packetCount
);

    mpWritePkg::tClNum              lenMask;
    mpWritePkg::tClNum              addrMismatch;
    logic                           lastBeat;

    // On an aligned packet the low address bits equal the beat number for
    // every bit covered by the length code
    assign lenMask      = mpWritePkg::tClNum'(txLen);
    assign addrMismatch = (txAddr[`MP_CLNUM_W-1:0] ^ nextBeatNum) & lenMask;
    assign lastBeat     = (nextBeatNum == lenMask);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            alignError  <= 1'b0;
            packetCount <= '0;
        end
        else if (txValid)
        begin
            if (addrMismatch != '0)
            begin
                alignError <= 1'b1;
            end

            if (lastBeat)
            begin
                packetCount <= packetCount + `MP_PKTCNT_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
source/mpWritePkg.sv
source/lineFillSequencer.sv
source/multiWriteTracker.sv
source/writeArbiter.sv
source/writeRequestChecker.sv
source/multiWriteTop.sv
sim/multiWriteTb.sv
